// ==== mac_pkg.sv ====
// widths, register map and constants for the keyed tag accelerator
// vault request/response structs and payload types

package mac_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int DATA_WIDTH  = 32;
  localparam int ADDR_WIDTH  = 8;
  localparam int KEY_WORDS   = 4;
  localparam int BLOCK_WORDS = 8;
  localparam int TAG_WORDS   = 4;
  localparam int ROUNDS      = 16;
  localparam int ENTRY_WIDTH = 3;

  // --------------------
  // register map, byte offsets
  // --------------------
  localparam logic [ADDR_WIDTH-1:0] REG_CTRL        = 8'h00;
  localparam logic [ADDR_WIDTH-1:0] REG_STATUS      = 8'h04;
  localparam logic [ADDR_WIDTH-1:0] REG_KV_RD_KEY   = 8'h08;
  localparam logic [ADDR_WIDTH-1:0] REG_KV_RD_BLOCK = 8'h0C;
  localparam logic [ADDR_WIDTH-1:0] REG_KV_WR       = 8'h10;
  localparam logic [ADDR_WIDTH-1:0] REG_KV_STATUS   = 8'h14;
  localparam logic [ADDR_WIDTH-1:0] REG_INTR        = 8'h18;
  localparam logic [ADDR_WIDTH-1:0] REG_KEY         = 8'h20;
  localparam logic [ADDR_WIDTH-1:0] REG_BLOCK       = 8'h40;
  localparam logic [ADDR_WIDTH-1:0] REG_TAG         = 8'h60;

  // state seed for init
  localparam logic [DATA_WIDTH-1:0] MAC_IV = 32'h6A09E667;

  // payloads, word 0 is the most significant
  typedef logic [0:KEY_WORDS-1][DATA_WIDTH-1:0]   key_t;
  typedef logic [0:BLOCK_WORDS-1][DATA_WIDTH-1:0] block_t;
  typedef logic [0:TAG_WORDS-1][DATA_WIDTH-1:0]   tag_t;

  // --------------------
  // vault ports
  // --------------------
  typedef struct packed {
    logic                   req;
    logic [ENTRY_WIDTH-1:0] entry;
    logic [3:0]             offset;
  } vault_rd_req_t;

  typedef struct packed {
    logic                  valid;
    logic                  err;
    logic [DATA_WIDTH-1:0] data;
  } vault_rd_resp_t;

  typedef struct packed {
    logic                   we;
    logic [ENTRY_WIDTH-1:0] entry;
    logic [3:0]             offset;
    logic [DATA_WIDTH-1:0]  data;
  } vault_wr_t;

  // en is a one-cycle pulse
  typedef struct packed {
    logic                   en;
    logic [ENTRY_WIDTH-1:0] entry;
  } vault_ctrl_t;

  // word fill from a read client into the register file
  typedef struct packed {
    logic                  we;
    logic [3:0]            offset;
    logic [DATA_WIDTH-1:0] data;
  } fill_t;

endpackage

// ==== mac_regs.sv ====
// AXI4-Lite slave and register file of the accelerator
// command pulses, per-word write locks, status and interrupt

module mac_regs #(
  parameter int ADDR_WIDTH = mac_pkg::ADDR_WIDTH,
  parameter int DATA_WIDTH = mac_pkg::DATA_WIDTH
) (
  input  logic                  clk,
  input  logic                  reset_n,
  // axi4-lite slave
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [ADDR_WIDTH-1:0] awaddr,
  input  logic                  wvalid,
  output logic                  wready,
  input  logic [DATA_WIDTH-1:0] wdata,
  output logic                  bvalid,
  input  logic                  bready,
  output logic [1:0]            bresp,
  input  logic                  arvalid,
  output logic                  arready,
  input  logic [ADDR_WIDTH-1:0] araddr,
  output logic                  rvalid,
  input  logic                  rready,
  output logic [DATA_WIDTH-1:0] rdata,
  output logic [1:0]            rresp,
  // vault clients, {err, done}
  input  mac_pkg::fill_t        key_fill,
  input  mac_pkg::fill_t        block_fill,
  input  logic [1:0]            key_status,
  input  logic [1:0]            block_status,
  input  logic                  vault_key,
  // core and result stage
  input  logic                  core_done,
  input  logic                  busy,
  input  mac_pkg::tag_t         sw_tag,
  input  logic                  tag_valid,
  input  logic                  wr_done,
  output mac_pkg::key_t         key,
  output mac_pkg::block_t       block,
  output logic                  init,
  output logic                  next,
  output logic                  zeroize,
  output mac_pkg::vault_ctrl_t  key_ctrl,
  output mac_pkg::vault_ctrl_t  block_ctrl,
  output mac_pkg::vault_ctrl_t  wr_ctrl,
  output logic                  notif_intr
);
  import mac_pkg::*;

  logic                   wr_fire;
  logic [KEY_WORDS-1:0]   key_lock;
  logic [BLOCK_WORDS-1:0] block_lock;
  logic [DATA_WIDTH-1:0]  rd_word;

  assign bresp   = 2'b00;
  assign rresp   = 2'b00;
  assign wready  = awready;
  // awaddr and wdata are still held by the master in the accept cycle
  assign wr_fire = awready;

  // --------------------
  // axi channels
  // --------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      awready <= 1'b0;
      bvalid  <= 1'b0;
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rdata   <= '0;
    end else begin
      awready <= awvalid && wvalid && !bvalid && !awready;
      if (awready) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      arready <= arvalid && !rvalid && !arready;
      if (arready) begin
        rvalid <= 1'b1;
        rdata  <= rd_word;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // read mux, unmapped offsets give zero
  always_comb begin
    rd_word = '0;
    case (araddr)
      REG_STATUS:      rd_word = DATA_WIDTH'({tag_valid, ~busy});
      REG_KV_RD_KEY:   rd_word = DATA_WIDTH'({key_ctrl.entry, 1'b0});
      REG_KV_RD_BLOCK: rd_word = DATA_WIDTH'({block_ctrl.entry, 1'b0});
      REG_KV_WR:       rd_word = DATA_WIDTH'({wr_ctrl.entry, 1'b0});
      REG_KV_STATUS:   rd_word = DATA_WIDTH'({key_status[1] | block_status[1], wr_done,
                                              block_status[0], key_status[0]});
      REG_INTR:        rd_word = DATA_WIDTH'(notif_intr);
      default:         rd_word = '0;
    endcase
    for (int i = 0; i < KEY_WORDS; i++) begin
      if (araddr == REG_KEY + ADDR_WIDTH'(4 * i)) rd_word = key[i];
    end
    for (int i = 0; i < BLOCK_WORDS; i++) begin
      if (araddr == REG_BLOCK + ADDR_WIDTH'(4 * i)) rd_word = block[i];
    end
    for (int i = 0; i < TAG_WORDS; i++) begin
      if (araddr == REG_TAG + ADDR_WIDTH'(4 * i)) rd_word = sw_tag[i];
    end
  end

  // --------------------
  // commands and vault controls
  // --------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      init       <= 1'b0;
      next       <= 1'b0;
      zeroize    <= 1'b0;
      key_ctrl   <= '0;
      block_ctrl <= '0;
      wr_ctrl    <= '0;
      notif_intr <= 1'b0;
    end else begin
      init          <= wr_fire && awaddr == REG_CTRL && wdata[0];
      next          <= wr_fire && awaddr == REG_CTRL && wdata[1];
      zeroize       <= wr_fire && awaddr == REG_CTRL && wdata[2];
      key_ctrl.en   <= wr_fire && awaddr == REG_KV_RD_KEY && wdata[0];
      block_ctrl.en <= wr_fire && awaddr == REG_KV_RD_BLOCK && wdata[0];
      wr_ctrl.en    <= wr_fire && awaddr == REG_KV_WR && wdata[0];
      if (wr_fire && awaddr == REG_KV_RD_KEY) key_ctrl.entry <= wdata[ENTRY_WIDTH:1];
      if (wr_fire && awaddr == REG_KV_RD_BLOCK) block_ctrl.entry <= wdata[ENTRY_WIDTH:1];
      if (wr_fire && awaddr == REG_KV_WR) wr_ctrl.entry <= wdata[ENTRY_WIDTH:1];
      // a new completion wins over a clear in the same cycle
      if (core_done) begin
        notif_intr <= 1'b1;
      end else if (wr_fire && awaddr == REG_INTR && wdata[0]) begin
        notif_intr <= 1'b0;
      end
    end
  end

  // --------------------
  // key and block words
  // --------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      key        <= '0;
      block      <= '0;
      key_lock   <= '0;
      block_lock <= '0;
    end else if (zeroize) begin
      key        <= '0;
      block      <= '0;
      key_lock   <= '0;
      block_lock <= '0;
    end else begin
      for (int i = 0; i < KEY_WORDS; i++) begin
        if (key_fill.we && key_fill.offset == 4'(i)) begin
          key[i]      <= key_fill.data;
          key_lock[i] <= 1'b1;
        end else begin
          if (wr_fire && awaddr == REG_KEY + ADDR_WIDTH'(4 * i) && !key_lock[i]) begin
            key[i] <= wdata;
          end
          // vault key released once its tag is out
          if (core_done && vault_key) key_lock[i] <= 1'b0;
        end
      end
      for (int i = 0; i < BLOCK_WORDS; i++) begin
        if (block_fill.we && block_fill.offset == 4'(i)) begin
          block[i]      <= block_fill.data;
          block_lock[i] <= 1'b1;
        end else begin
          if (wr_fire && awaddr == REG_BLOCK + ADDR_WIDTH'(4 * i) && !block_lock[i]) begin
            block[i] <= wdata;
          end
          if (init || next) block_lock[i] <= 1'b0;
        end
      end
    end
  end

endmodule

// ==== vault_read_client.sv ====
// vault read client, fetches one entry word by word
// and fills the key or block registers

module vault_read_client #(
  parameter type payload_t = mac_pkg::key_t,
  parameter int  NUM_WORDS = $bits(payload_t) / mac_pkg::DATA_WIDTH
) (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    zeroize,
  input  mac_pkg::vault_ctrl_t    ctrl,
  output mac_pkg::vault_rd_req_t  req,
  input  mac_pkg::vault_rd_resp_t resp,
  output mac_pkg::fill_t          fill,
  output logic                    done,
  output logic                    err
);
  import mac_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_WAIT
  } state_t;

  state_t                 state;
  logic [ENTRY_WIDTH-1:0] entry;
  logic [3:0]             offset;
  logic                   last;

  assign last = offset == 4'(NUM_WORDS - 1);

  // one request in flight at a time
  assign req.req    = state == S_REQ;
  assign req.entry  = entry;
  assign req.offset = offset;

  assign fill.we     = state == S_WAIT && resp.valid && !resp.err;
  assign fill.offset = offset;
  assign fill.data   = resp.data;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state  <= S_IDLE;
      entry  <= '0;
      offset <= '0;
      done   <= 1'b0;
      err    <= 1'b0;
    end else if (zeroize) begin
      state  <= S_IDLE;
      offset <= '0;
      done   <= 1'b0;
      err    <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (ctrl.en) begin
            entry  <= ctrl.entry;
            offset <= '0;
            done   <= 1'b0;
            err    <= 1'b0;
            state  <= S_REQ;
          end
        end
        S_REQ: state <= S_WAIT;
        S_WAIT: begin
          if (resp.valid) begin
            if (resp.err) begin
              // abandon the entry, remaining words untouched
              done  <= 1'b1;
              err   <= 1'b1;
              state <= S_IDLE;
            end else if (last) begin
              done  <= 1'b1;
              state <= S_IDLE;
            end else begin
              offset <= offset + 4'd1;
              state  <= S_REQ;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// ==== mac_core.sv ====
// keyed mixing core, 16 rounds at one round per cycle
// init seeds the state from the key, next chains from the last tag

module mac_core (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            zeroize,
  input  logic            init,
  input  logic            next,
  input  mac_pkg::key_t   key,
  input  mac_pkg::block_t block,
  output mac_pkg::tag_t   tag,
  output logic            busy,
  output logic            done
);
  import mac_pkg::*;

  localparam int RW = $clog2(ROUNDS);
  localparam int BW = $clog2(BLOCK_WORDS);

  tag_t                  state;
  logic [RW-1:0]         round;
  logic [DATA_WIDTH-1:0] mixed;
  logic [DATA_WIDTH-1:0] t;

  // --------------------
  // round function
  // --------------------
  assign mixed = state[0] ^ block[round[BW-1:0]];
  // rotl 7, then add s3 and the round index
  assign t = {mixed[DATA_WIDTH-8:0], mixed[DATA_WIDTH-1:DATA_WIDTH-7]}
           + state[3] + DATA_WIDTH'(round);

  assign tag = state;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= '0;
      round <= '0;
      busy  <= 1'b0;
      done  <= 1'b0;
    end else if (zeroize) begin
      state <= '0;
      round <= '0;
      busy  <= 1'b0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      if (busy) begin
        state <= {state[1], state[2], state[3], t};
        round <= round + 1'b1;
        if (round == RW'(ROUNDS - 1)) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end else if (init || next) begin
        // next leaves the state alone so blocks chain
        if (init) begin
          for (int i = 0; i < KEY_WORDS; i++) begin
            state[i] <= key[i] ^ MAC_IV;
          end
        end
        round <= '0;
        busy  <= 1'b1;
      end
    end
  end

endmodule

// ==== mac_result.sv ====
// result stage, captures the tag at done
// routes it to the software tag registers or streams it to the vault

module mac_result (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 zeroize,
  input  logic                 done,
  input  mac_pkg::tag_t        tag,
  input  mac_pkg::vault_ctrl_t wr_ctrl,
  input  logic                 vault_key,
  input  logic                 init,
  input  logic                 next,
  output mac_pkg::tag_t        sw_tag,
  output logic                 tag_valid,
  output mac_pkg::vault_wr_t   vault_wr,
  output logic                 wr_done
);
  import mac_pkg::*;

  logic                   wr_armed;
  logic [ENTRY_WIDTH-1:0] wr_entry;
  logic                   vault_key_d;
  logic                   key_from_vault;
  logic                   to_vault;
  logic                   streaming;
  logic [3:0]             wr_cnt;
  tag_t                   hold;

  assign to_vault = wr_armed || key_from_vault;

  // posted writes, one word per cycle
  assign vault_wr.we     = streaming;
  assign vault_wr.entry  = wr_entry;
  assign vault_wr.offset = wr_cnt;
  assign vault_wr.data   = hold[wr_cnt];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      hold <= '0;
    end else if (zeroize) begin
      hold <= '0;
    end else if (done && to_vault) begin
      hold <= tag;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      sw_tag         <= '0;
      tag_valid      <= 1'b0;
      wr_armed       <= 1'b0;
      wr_entry       <= '0;
      vault_key_d    <= 1'b0;
      key_from_vault <= 1'b0;
      streaming      <= 1'b0;
      wr_cnt         <= '0;
      wr_done        <= 1'b0;
    end else if (zeroize) begin
      sw_tag         <= '0;
      tag_valid      <= 1'b0;
      wr_armed       <= 1'b0;
      key_from_vault <= 1'b0;
      streaming      <= 1'b0;
      wr_cnt         <= '0;
      wr_done        <= 1'b0;
    end else begin
      vault_key_d <= vault_key;
      if (init || next) tag_valid <= 1'b0;

      // --------------------
      // capture and route
      // --------------------
      if (done) begin
        tag_valid <= 1'b1;
        if (to_vault) begin
          streaming      <= 1'b1;
          wr_cnt         <= '0;
          wr_armed       <= 1'b0;
          key_from_vault <= 1'b0;
        end else begin
          sw_tag <= tag;
        end
      end
      if (streaming) begin
        wr_cnt <= wr_cnt + 4'd1;
        if (wr_cnt == 4'(TAG_WORDS - 1)) begin
          streaming <= 1'b0;
          wr_done   <= 1'b1;
        end
      end

      // new key fetched from the vault since the last tag
      if (vault_key && !vault_key_d) key_from_vault <= 1'b1;
      if (wr_ctrl.en) begin
        wr_armed <= 1'b1;
        wr_entry <= wr_ctrl.entry;
        wr_done  <= 1'b0;
      end
    end
  end

endmodule

// ==== mac_top.sv ====
// accelerator top level
// register front end, vault read clients, core and result stage

module mac_top #(
  parameter int ADDR_WIDTH = mac_pkg::ADDR_WIDTH,
  parameter int DATA_WIDTH = mac_pkg::DATA_WIDTH
) (
  input  logic                    clk,
  input  logic                    reset_n,
  // axi4-lite slave
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [ADDR_WIDTH-1:0]   awaddr,
  input  logic                    wvalid,
  output logic                    wready,
  input  logic [DATA_WIDTH-1:0]   wdata,
  output logic                    bvalid,
  input  logic                    bready,
  output logic [1:0]              bresp,
  input  logic                    arvalid,
  output logic                    arready,
  input  logic [ADDR_WIDTH-1:0]   araddr,
  output logic                    rvalid,
  input  logic                    rready,
  output logic [DATA_WIDTH-1:0]   rdata,
  output logic [1:0]              rresp,
  // key vault
  output mac_pkg::vault_rd_req_t  key_rd_req,
  input  mac_pkg::vault_rd_resp_t key_rd_resp,
  output mac_pkg::vault_rd_req_t  block_rd_req,
  input  mac_pkg::vault_rd_resp_t block_rd_resp,
  output mac_pkg::vault_wr_t      vault_wr,
  output logic                    notif_intr
);
  import mac_pkg::*;

  fill_t       key_fill;
  fill_t       block_fill;
  logic        key_done;
  logic        key_err;
  logic        block_done;
  logic        block_err;
  logic        vault_key;
  key_t        key;
  block_t      block;
  logic        init;
  logic        next;
  logic        zeroize;
  vault_ctrl_t key_ctrl;
  vault_ctrl_t block_ctrl;
  vault_ctrl_t wr_ctrl;
  tag_t        core_tag;
  tag_t        sw_tag;
  logic        busy;
  logic        core_done;
  logic        tag_valid;
  logic        wr_done;

  // clean vault key read
  assign vault_key = key_done && !key_err;

  mac_regs #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH)
  ) u_regs (
    .clk, .reset_n,
    .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .bvalid, .bready, .bresp,
    .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
    .key_fill, .block_fill,
    .key_status   ({key_err, key_done}),
    .block_status ({block_err, block_done}),
    .vault_key, .core_done, .busy, .sw_tag, .tag_valid, .wr_done,
    .key, .block, .init, .next, .zeroize,
    .key_ctrl, .block_ctrl, .wr_ctrl, .notif_intr
  );

  // --------------------
  // vault read clients
  // --------------------
  vault_read_client #(
    .payload_t (key_t)
  ) key_client (
    .clk, .reset_n, .zeroize,
    .ctrl (key_ctrl),
    .req  (key_rd_req),
    .resp (key_rd_resp),
    .fill (key_fill),
    .done (key_done),
    .err  (key_err)
  );

  vault_read_client #(
    .payload_t (block_t)
  ) block_client (
    .clk, .reset_n, .zeroize,
    .ctrl (block_ctrl),
    .req  (block_rd_req),
    .resp (block_rd_resp),
    .fill (block_fill),
    .done (block_done),
    .err  (block_err)
  );

  mac_core u_core (
    .clk, .reset_n, .zeroize, .init, .next, .key, .block,
    .tag  (core_tag),
    .busy,
    .done (core_done)
  );

  mac_result u_result (
    .clk, .reset_n, .zeroize,
    .done (core_done),
    .tag  (core_tag),
    .wr_ctrl, .vault_key, .init, .next,
    .sw_tag, .tag_valid, .vault_wr, .wr_done
  );

endmodule

// ==== mac_checker.sv ====
// testbench checker for AXI read data, vault writes and the interrupt
// compares against posted expectations, keeps per-test and total counts

module mac_checker (
  input logic                           clk,
  input logic                           rvalid,
  input logic                           rready,
  input logic [mac_pkg::DATA_WIDTH-1:0] rdata,
  input logic [1:0]                     rresp,
  input logic                           bvalid,
  input logic                           bready,
  input logic [1:0]                     bresp,
  input logic                           notif_intr,
  input mac_pkg::vault_wr_t             vault_wr
);
  import mac_pkg::*;

  typedef struct packed {
    logic [31:0] value;
    logic [31:0] mask;
  } rd_exp_t;

  string     rd_names [$];
  rd_exp_t   rd_q [$];
  vault_wr_t wr_q [$];
  int        check_count = 0;
  int        error_count = 0;
  int        test_errors = 0;
  int        test_num    = 0;
  int        wr_seen     = 0;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    error_count++;
    test_errors++;
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      $display("ERR %s: got 0x%08h, expected 0x%08h", name, got, exp);
      error_count++;
      test_errors++;
    end
  endtask

  // --------------------
  // expectations from the sequence
  // --------------------
  task automatic expect_read(input string name, input logic [31:0] value,
                             input logic [31:0] mask);
    rd_names.push_back(name);
    rd_q.push_back('{value: value, mask: mask});
  endtask

  task automatic expect_vault_write(input logic [2:0] entry, input logic [3:0] offset,
                                    input logic [31:0] data);
    wr_q.push_back('{we: 1'b1, entry: entry, offset: offset, data: data});
  endtask

  task automatic check_intr(input logic exp);
    @(negedge clk);
    compare("notif_intr", 32'(notif_intr), 32'(exp));
  endtask

  task automatic check_bvalid(input logic exp);
    @(negedge clk);
    compare("bvalid", 32'(bvalid), 32'(exp));
  endtask

  // outputs are settled at the falling edge
  always @(negedge clk) begin
    rd_exp_t   cur;
    string     cur_name;
    vault_wr_t wr;
    if (bvalid && bready) begin
      compare("bresp", 32'(bresp), 32'h0);
    end
    if (rvalid && rready) begin
      compare("rresp", 32'(rresp), 32'h0);
      if (rd_q.size() == 0) begin
        report_failure("read data returned with no read expected");
      end else begin
        cur      = rd_q.pop_front();
        cur_name = rd_names.pop_front();
        if (cur.mask != '0) compare(cur_name, rdata & cur.mask, cur.value & cur.mask);
      end
    end
    if (vault_wr.we) begin
      wr_seen++;
      if (wr_q.size() == 0) begin
        report_failure("vault write appeared with none expected");
      end else begin
        wr = wr_q.pop_front();
        compare("vault_wr.entry", 32'(vault_wr.entry), 32'(wr.entry));
        compare("vault_wr.offset", 32'(vault_wr.offset), 32'(wr.offset));
        compare("vault_wr.data", vault_wr.data, wr.data);
      end
    end
  end

  task automatic end_test(input string name);
    test_num++;
    if (wr_q.size() != 0) begin
      report_failure($sformatf("%0d expected vault writes never appeared", wr_q.size()));
      wr_q.delete();
    end
    if (test_errors == 0) begin
      $display("test %0d %s: ok", test_num, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", test_num, name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic final_counts();
    $display("tests %0d, checks %0d, vault writes %0d, errors %0d",
             test_num, check_count, wr_seen, error_count);
  endtask

endmodule

// ==== tb_mac.sv ====
// testbench top for the keyed tag accelerator
// clock and reset, AXI4-Lite tasks, vault model, reference model, test sequence

module tb_mac;
  import mac_pkg::*;

  localparam int          WAIT_LIMIT = 40;
  localparam int          POLL_LIMIT = 30;
  localparam logic [31:0] ALL        = 32'hFFFFFFFF;

  logic                  clk;
  logic                  reset_n;
  logic                  awvalid;
  logic                  awready;
  logic [ADDR_WIDTH-1:0] awaddr;
  logic                  wvalid;
  logic                  wready;
  logic [DATA_WIDTH-1:0] wdata;
  logic                  bvalid;
  logic                  bready;
  logic [1:0]            bresp;
  logic                  arvalid;
  logic                  arready;
  logic [ADDR_WIDTH-1:0] araddr;
  logic                  rvalid;
  logic                  rready;
  logic [DATA_WIDTH-1:0] rdata;
  logic [1:0]            rresp;
  vault_rd_req_t         key_rd_req;
  vault_rd_resp_t        key_rd_resp;
  vault_rd_req_t         block_rd_req;
  vault_rd_resp_t        block_rd_resp;
  vault_wr_t             vault_wr;
  logic                  notif_intr;

  key_t                  key_q;
  block_t                blk_q;
  tag_t                  state_q;
  tag_t                  sw_tag_q;

  mac_top #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH)
  ) uut (.*);

  mac_checker chk (.*);

  always #4 clk = ~clk;

  // --------------------
  // vault model
  // --------------------
  function automatic logic [31:0] vault_word(input logic [2:0] entry, input logic [3:0] offset);
    return (32'(entry) * 32'h01010101) ^ (32'(offset) * 32'h10000001);
  endfunction

  function automatic vault_rd_resp_t vault_answer(input vault_rd_req_t rq);
    vault_rd_resp_t rs;
    rs.valid = rq.req;
    // entry 7 is a protected slot
    rs.err   = rq.req && rq.entry == 3'd7;
    rs.data  = rq.req ? vault_word(rq.entry, rq.offset) : '0;
    return rs;
  endfunction

  // one response per request, in the following cycle
  always @(posedge clk) begin
    key_rd_resp   <= vault_answer(key_rd_req);
    block_rd_resp <= vault_answer(block_rd_req);
  end

  // reference model of the 16-round keyed mix
  function automatic tag_t mac_ref(input key_t k, input block_t b, input tag_t chain,
                                   input bit is_next);
    logic [31:0] s [0:3];
    logic [31:0] x;
    tag_t        res;
    for (int i = 0; i < 4; i++) begin
      s[i] = is_next ? chain[i] : (k[i] ^ 32'h6A09E667);
    end
    for (int r = 0; r < 16; r++) begin
      x = s[0] ^ b[r % 8];
      x = (x << 7) | (x >> 25);
      x = x + s[3] + 32'(r);
      s[0] = s[1];
      s[1] = s[2];
      s[2] = s[3];
      s[3] = x;
    end
    for (int i = 0; i < 4; i++) begin
      res[i] = s[i];
    end
    return res;
  endfunction

  function automatic key_t random_key();
    key_t k;
    for (int i = 0; i < KEY_WORDS; i++) begin
      k[i] = $urandom();
    end
    return k;
  endfunction

  function automatic block_t random_block();
    block_t b;
    for (int i = 0; i < BLOCK_WORDS; i++) begin
      b[i] = $urandom();
    end
    return b;
  endfunction

  // --------------------
  // axi4-lite master
  // --------------------
  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data, input int hold);
    int n;
    @(posedge clk);
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    awaddr  <= addr;
    wdata   <= data;
    bready  <= (hold == 0);
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!(awready && wready) && n < WAIT_LIMIT);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    if (!(awready && wready)) begin
      chk.report_failure($sformatf("write to 0x%02h was never accepted", addr));
    end
    // response held off while bready is low
    if (hold > 0) begin
      for (int i = 0; i < hold; i++) begin
        chk.check_bvalid(1'b1);
      end
      @(posedge clk);
      bready <= 1'b1;
    end
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!bvalid && n < WAIT_LIMIT);
    if (!bvalid) chk.report_failure($sformatf("write to 0x%02h got no response", addr));
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
    int n;
    @(posedge clk);
    arvalid <= 1'b1;
    araddr  <= addr;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!arready && n < WAIT_LIMIT);
    arvalid <= 1'b0;
    if (!arready) chk.report_failure($sformatf("read of 0x%02h was never accepted", addr));
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!rvalid && n < WAIT_LIMIT);
    if (!rvalid) chk.report_failure($sformatf("read of 0x%02h returned no data", addr));
    data = rdata;
  endtask

  task automatic check_read(input string name, input logic [7:0] addr, input logic [31:0] exp,
                            input logic [31:0] mask);
    logic [31:0] d;
    chk.expect_read(name, exp, mask);
    axi_read(addr, d);
  endtask

  task automatic wait_bit(input logic [7:0] addr, input logic [31:0] mask, input string what);
    logic [31:0] d;
    int          n;
    d = '0;
    n = 0;
    while ((d & mask) == '0 && n < POLL_LIMIT) begin
      chk.expect_read("poll", '0, '0);
      axi_read(addr, d);
      n++;
    end
    if ((d & mask) == '0) chk.report_failure({what, " was never set"});
  endtask

  task automatic write_key(input key_t k);
    for (int i = 0; i < KEY_WORDS; i++) begin
      axi_write(REG_KEY + 8'(4 * i), k[i], 0);
    end
  endtask

  task automatic write_block(input block_t b);
    for (int i = 0; i < BLOCK_WORDS; i++) begin
      axi_write(REG_BLOCK + 8'(4 * i), b[i], 0);
    end
  endtask

  task automatic check_tag(input tag_t t);
    for (int i = 0; i < TAG_WORDS; i++) begin
      check_read($sformatf("TAG[%0d]", i), REG_TAG + 8'(4 * i), t[i], ALL);
    end
  endtask

  task automatic expect_tag_writes(input logic [2:0] entry, input tag_t t);
    for (int i = 0; i < TAG_WORDS; i++) begin
      chk.expect_vault_write(entry, 4'(i), t[i]);
    end
  endtask

  // --------------------
  // test sequence
  // --------------------
  initial begin
    clk           = 1'b0;
    reset_n       = 1'b0;
    awvalid       = 1'b0;
    awaddr        = '0;
    wvalid        = 1'b0;
    wdata         = '0;
    bready        = 1'b1;
    arvalid       = 1'b0;
    araddr        = '0;
    rready        = 1'b1;
    key_rd_resp   = '0;
    block_rd_resp = '0;
    state_q       = '0;
    sw_tag_q      = '0;
    void'($urandom(84));
    repeat (3) @(posedge clk);
    reset_n <= 1'b1;

    key_q = random_key();
    blk_q = random_block();
    write_key(key_q);
    write_block(blk_q);
    axi_write(REG_CTRL, 32'h1, 0);
    wait_bit(REG_STATUS, 32'h2, "STATUS.valid");
    state_q  = mac_ref(key_q, blk_q, state_q, 1'b0);
    sw_tag_q = state_q;
    check_tag(sw_tag_q);
    chk.check_intr(1'b1);
    axi_write(REG_INTR, 32'h1, 0);
    chk.check_intr(1'b0);
    chk.end_test("software key and block, init");

    blk_q = random_block();
    write_block(blk_q);
    axi_write(REG_CTRL, 32'h2, 0);
    wait_bit(REG_STATUS, 32'h2, "STATUS.valid");
    state_q  = mac_ref(key_q, blk_q, state_q, 1'b1);
    sw_tag_q = state_q;
    check_tag(sw_tag_q);
    chk.end_test("chained block, next");

    // key from vault entry 2, block from entry 3
    axi_write(REG_KV_RD_KEY, 32'h5, 0);
    wait_bit(REG_KV_STATUS, 32'h1, "key read done");
    axi_write(REG_KV_RD_BLOCK, 32'h7, 0);
    wait_bit(REG_KV_STATUS, 32'h2, "block read done");
    for (int i = 0; i < KEY_WORDS; i++) begin
      key_q[i] = vault_word(3'd2, 4'(i));
    end
    for (int i = 0; i < BLOCK_WORDS; i++) begin
      blk_q[i] = vault_word(3'd3, 4'(i));
    end
    // locked word, must be ignored
    axi_write(REG_KEY, $urandom(), 0);
    state_q = mac_ref(key_q, blk_q, state_q, 1'b0);
    // no write control yet, entry still at its reset value
    expect_tag_writes(3'd0, state_q);
    axi_write(REG_CTRL, 32'h1, 0);
    wait_bit(REG_STATUS, 32'h2, "STATUS.valid");
    wait_bit(REG_KV_STATUS, 32'h4, "vault write done");
    check_tag(sw_tag_q);
    chk.end_test("vault key and block, tag to vault");

    axi_write(REG_KV_WR, 32'hB, 0);
    key_q = random_key();
    blk_q = random_block();
    write_key(key_q);
    write_block(blk_q);
    state_q = mac_ref(key_q, blk_q, state_q, 1'b0);
    expect_tag_writes(3'd5, state_q);
    axi_write(REG_CTRL, 32'h1, 0);
    wait_bit(REG_STATUS, 32'h2, "STATUS.valid");
    wait_bit(REG_KV_STATUS, 32'h4, "vault write done");
    check_read("KV_STATUS.write_done", REG_KV_STATUS, 32'h4, 32'h4);
    chk.end_test("armed write control, entry 5");

    axi_write(REG_KV_RD_KEY, 32'hF, 0);
    wait_bit(REG_KV_STATUS, 32'h1, "key read done");
    check_read("KV_STATUS.read_err", REG_KV_STATUS, 32'h8, 32'h8);
    axi_write(REG_CTRL, 32'h4, 0);
    for (int i = 0; i < KEY_WORDS; i++) begin
      check_read($sformatf("KEY[%0d]", i), REG_KEY + 8'(4 * i), '0, ALL);
    end
    for (int i = 0; i < BLOCK_WORDS; i++) begin
      check_read($sformatf("BLOCK[%0d]", i), REG_BLOCK + 8'(4 * i), '0, ALL);
    end
    sw_tag_q = '0;
    state_q  = '0;
    check_tag(sw_tag_q);
    check_read("STATUS.valid", REG_STATUS, '0, 32'h2);
    chk.end_test("read error and zeroize");

    check_read("unmapped 0x1C", 8'h1C, '0, ALL);
    axi_write(REG_INTR, 32'h1, 4);
    chk.check_bvalid(1'b0);
    chk.end_test("unmapped read and held response");

    chk.final_counts();
    if (chk.error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== src.f ====
mac_pkg.sv
mac_regs.sv
vault_read_client.sv
mac_core.sv
mac_result.sv
mac_top.sv
mac_checker.sv
tb_mac.sv

// ==== Bender.yml ====
package:
  name: mac_accel

sources:
  - mac_pkg.sv
  - mac_regs.sv
  - vault_read_client.sv
  - mac_core.sv
  - mac_result.sv
  - mac_top.sv
  - target: test
    files:
      - mac_checker.sv
      - tb_mac.sv
